//--- build.f
source/mdu_pkg.sv
source/mul_pipeline.sv
source/result_fifo.sv
source/mul_unit.sv
source/div_unit.sv
source/wb_arbiter.sv
source/mdu_top.sv
verification/mdu_clock.sv
verification/mdu_assert.sv
verification/mdu_tb.sv

//--- run.sh
#!/bin/sh
# builds the MDU testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mdu_tb -f build.f -o mdu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mdu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- source/div_unit.sv
`timescale 1ns/1ps

module div_unit #(
    parameter int div_buffer_depth = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     request,
    input  mdu_pkg::mdu_op_t         op,
    input  logic [mdu_pkg::xlen-1:0] rs1,
    input  logic [mdu_pkg::xlen-1:0] rs2,
    input  mdu_pkg::tag_t            tag,
    output logic                     ready,
    output logic                     valid,
    output logic [mdu_pkg::xlen-1:0] result,
    output mdu_pkg::tag_t            result_tag,
    input  logic                     accepted
);
    import mdu_pkg::*;

    localparam int count_width = $clog2(div_buffer_depth + 1);

    typedef enum logic [1:0] {s_idle, s_load, s_iter, s_fix} div_state_t;

    div_state_t             state;
    logic [$clog2(xlen)-1:0] step;         // iteration index.
    logic [count_width-1:0] buffered;      // entries in the output buffer.
    mdu_op_t                op_r;
    tag_t                   tag_r;
    logic [xlen-1:0]        dividend;      // raw operands, kept for special cases.
    logic [xlen-1:0]        divisor_raw;
    logic [xlen-1:0]        divisor;       // magnitude.
    logic [xlen-1:0]        quo;           // dividend shifts out, quotient shifts in.
    logic [xlen-1:0]        rem;
    logic                   neg_q;
    logic                   neg_r;
    logic [xlen:0]          shifted;
    logic [xlen+1:0]        diff;
    logic                   op_signed;
    logic                   div_zero;
    logic                   overflow;
    logic [xlen-1:0]        q_final;
    logic [xlen-1:0]        r_final;
    logic                   take;
    logic                   push;
    logic                   drain;

    assign take = request & ready;
    assign push = (state == s_fix);  // one fix-up cycle, entry written at its end.
    assign drain = valid & accepted;
    assign ready = (state == s_idle) && (buffered < count_width'(div_buffer_depth));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            step <= '0;
            buffered <= '0;
        end else begin
            case (state)
                s_idle: if (take) state <= s_load;
                s_load: begin
                    state <= s_iter;
                    step <= '0;
                end
                s_iter: begin
                    step <= step + 1'b1;
                    if (step == $clog2(xlen)'(xlen - 1)) state <= s_fix;  // 32 steps done.
                end
                default: state <= s_idle;
            endcase
            if (push && !drain) buffered <= buffered + 1'b1;
            else if (!push && drain) buffered <= buffered - 1'b1;
        end
    end

    assign op_signed = (op_r == op_div) || (op_r == op_rem);
    assign shifted = {rem, quo[xlen-1]};
    assign diff = {1'b0, shifted} - {2'b00, divisor};  // msb set means borrow.

    always_ff @(posedge clk) begin
        if (take) begin
            op_r <= op;
            tag_r <= tag;
            dividend <= rs1;
            divisor_raw <= rs2;
        end
        if (state == s_load) begin
            quo <= (op_signed && dividend[xlen-1]) ? -dividend : dividend;
            divisor <= (op_signed && divisor_raw[xlen-1]) ? -divisor_raw : divisor_raw;
            rem <= '0;
            neg_q <= op_signed & (dividend[xlen-1] ^ divisor_raw[xlen-1]);
            neg_r <= op_signed & dividend[xlen-1];  // remainder follows the dividend.
        end
        if (state == s_iter) begin
            if (!diff[xlen+1]) begin
                rem <= diff[xlen-1:0];   // subtract fits, keep it.
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= shifted[xlen-1:0];  // restore.
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end
    end

    // sign fix-up, then the RISC-V special cases override.
    assign div_zero = (divisor_raw == '0);
    assign overflow = op_signed && (dividend == {1'b1, {(xlen-1){1'b0}}}) && (&divisor_raw);

    always_comb begin
        q_final = neg_q ? -quo : quo;
        r_final = neg_r ? -rem : rem;
        if (div_zero) begin
            q_final = '1;
            r_final = dividend;
        end else if (overflow) begin
            q_final = dividend;
            r_final = '0;
        end
    end

    result_fifo #(
        .depth(div_buffer_depth)
    ) output_buffer (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_data(((op_r == op_rem) || (op_r == op_remu)) ? r_final : q_final),
        .push_tag (tag_r),
        .pop      (drain),
        .valid    (valid),
        .data     (result),
        .data_tag (result_tag)
    );

endmodule

//--- source/mdu_pkg.sv
package mdu_pkg;

    localparam int xlen = 32;      // operand and result width.
    localparam int tag_width = 3;  // request tag width.

    typedef logic [tag_width-1:0] tag_t;

    // operation codes follow the funct3 field of the M extension.
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } mdu_op_t;

    // upper half of the code space belongs to the divider.
    function automatic logic is_div_op(input mdu_op_t op);
        return op[2];
    endfunction

    // rs1 is unsigned only for mulhu.
    // for mul the low word is the same either way, so signed is fine.
    function automatic logic operand_signed_a(input mdu_op_t op);
        return op != op_mulhu;
    endfunction

    // rs2 is signed for mul and mulh only.
    function automatic logic operand_signed_b(input mdu_op_t op);
        return (op == op_mul) || (op == op_mulh);
    endfunction

endpackage

//--- source/mdu_top.sv
`timescale 1ns/1ps

module mdu_top #(
    parameter int mul_cycles = 2,
    parameter int mul_buffer_depth = 4,
    parameter int div_buffer_depth = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mul_request,
    input  mdu_pkg::mdu_op_t         mul_op,
    input  logic [mdu_pkg::xlen-1:0] mul_rs1,
    input  logic [mdu_pkg::xlen-1:0] mul_rs2,
    input  mdu_pkg::tag_t            mul_tag,
    output logic                     mul_ready,
    input  logic                     div_request,
    input  mdu_pkg::mdu_op_t         div_op,
    input  logic [mdu_pkg::xlen-1:0] div_rs1,
    input  logic [mdu_pkg::xlen-1:0] div_rs2,
    input  mdu_pkg::tag_t            div_tag,
    output logic                     div_ready,
    output logic                     wb_valid,
    output logic [mdu_pkg::xlen-1:0] wb_result,
    output mdu_pkg::tag_t            wb_tag,
    input  logic                     wb_accepted
);
    import mdu_pkg::*;

    logic            mul_valid;     // multiply buffer head.
    logic [xlen-1:0] mul_result;
    tag_t            mul_result_tag;
    logic            mul_accepted;
    logic            div_valid;     // divide buffer head.
    logic [xlen-1:0] div_result;
    tag_t            div_result_tag;
    logic            div_accepted;

    mul_unit #(
        .mul_cycles      (mul_cycles),
        .mul_buffer_depth(mul_buffer_depth)
    ) mul (
        .clk(clk), .rst(rst),
        .request(mul_request), .op(mul_op), .rs1(mul_rs1), .rs2(mul_rs2), .tag(mul_tag),
        .ready(mul_ready),
        .valid(mul_valid), .result(mul_result), .result_tag(mul_result_tag),
        .accepted(mul_accepted)
    );

    div_unit #(
        .div_buffer_depth(div_buffer_depth)
    ) div (
        .clk(clk), .rst(rst),
        .request(div_request), .op(div_op), .rs1(div_rs1), .rs2(div_rs2), .tag(div_tag),
        .ready(div_ready),
        .valid(div_valid), .result(div_result), .result_tag(div_result_tag),
        .accepted(div_accepted)
    );

    // merges both result streams onto the writeback port.
    wb_arbiter arbiter (
        .clk(clk), .rst(rst),
        .mul_valid(mul_valid), .mul_result(mul_result), .mul_tag(mul_result_tag),
        .mul_accepted(mul_accepted),
        .div_valid(div_valid), .div_result(div_result), .div_tag(div_result_tag),
        .div_accepted(div_accepted),
        .wb_valid(wb_valid), .wb_result(wb_result), .wb_tag(wb_tag),
        .wb_accepted(wb_accepted)
    );

endmodule

//--- source/mul_pipeline.sv
`timescale 1ns/1ps

module mul_pipeline #(
    parameter int mul_cycles = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [mdu_pkg::xlen-1:0] a,
    input  logic [mdu_pkg::xlen-1:0] b,
    input  logic                     signed_a,
    input  logic                     signed_b,
    input  logic                     upper,
    input  mdu_pkg::tag_t            tag,
    output logic                     done,
    output logic [mdu_pkg::xlen-1:0] product_word,
    output mdu_pkg::tag_t            done_tag
);
    import mdu_pkg::*;

    logic signed [xlen:0]     a_ext;         // 33-bit operands.
    logic signed [xlen:0]     b_ext;
    logic signed [2*xlen+1:0] full_product;  // 66-bit signed product.

    // per-stage state, index 0 is the first register after the multiplier.
    logic [2*xlen-1:0] stage_product [mul_cycles];
    logic              stage_valid   [mul_cycles];
    logic              stage_upper   [mul_cycles];
    tag_t              stage_tag     [mul_cycles];

    // sign or zero extension picks the operand interpretation.
    assign a_ext = {signed_a & a[xlen-1], a};
    assign b_ext = {signed_b & b[xlen-1], b};
    assign full_product = a_ext * b_ext;  // only the low 64 bits matter after this.

    // valid bits walk the pipe with the data, never stalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mul_cycles; i++) begin
                stage_valid[i] <= 1'b0;
            end
        end else begin
            stage_valid[0] <= start;
            for (int i = 1; i < mul_cycles; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage_product[0] <= full_product[2*xlen-1:0];
        stage_upper[0] <= upper;
        stage_tag[0] <= tag;
        for (int i = 1; i < mul_cycles; i++) begin
            stage_product[i] <= stage_product[i-1];  // shift product down the pipe.
            stage_upper[i] <= stage_upper[i-1];
            stage_tag[i] <= stage_tag[i-1];
        end
    end

    assign done = stage_valid[mul_cycles-1];
    assign done_tag = stage_tag[mul_cycles-1];
    // high word for mulh variants, low word for mul.
    assign product_word = stage_upper[mul_cycles-1] ? stage_product[mul_cycles-1][2*xlen-1:xlen]
                                                    : stage_product[mul_cycles-1][xlen-1:0];

endmodule

//--- source/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int mul_cycles = 2,
    parameter int mul_buffer_depth = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     request,
    input  mdu_pkg::mdu_op_t         op,
    input  logic [mdu_pkg::xlen-1:0] rs1,
    input  logic [mdu_pkg::xlen-1:0] rs2,
    input  mdu_pkg::tag_t            tag,
    output logic                     ready,
    output logic                     valid,
    output logic [mdu_pkg::xlen-1:0] result,
    output mdu_pkg::tag_t            result_tag,
    input  logic                     accepted
);
    import mdu_pkg::*;

    localparam int count_width = $clog2(mul_buffer_depth + 1);

    logic [count_width-1:0] inflight;       // pipeline plus buffer occupancy.
    logic [count_width-1:0] inflight_next;
    logic                   new_request;
    logic                   drain;
    logic                   mul_done;
    logic [xlen-1:0]        mul_word;
    tag_t                   mul_tag;

    assign new_request = request & ready;
    assign drain = valid & accepted;  // entry leaves the buffer.

    always_comb begin
        inflight_next = inflight;
        if (new_request && !drain) inflight_next = inflight + 1'b1;
        else if (!new_request && drain) inflight_next = inflight - 1'b1;
    end

    // ready is a register, so issue never sees a combinational path from writeback.
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= '0;
            ready <= 1'b1;
        end else begin
            inflight <= inflight_next;
            ready <= (inflight_next < count_width'(mul_buffer_depth));
        end
    end

    mul_pipeline #(
        .mul_cycles(mul_cycles)
    ) pipeline (
        .clk         (clk),
        .rst         (rst),
        .start       (new_request),
        .a           (rs1),
        .b           (rs2),
        .signed_a    (operand_signed_a(op)),
        .signed_b    (operand_signed_b(op)),
        .upper       (op != op_mul),        // every other code wants the high word.
        .tag         (tag),
        .done        (mul_done),
        .product_word(mul_word),
        .done_tag    (mul_tag)
    );

    // pipeline output lands here, space is guaranteed by the in-flight count.
    result_fifo #(
        .depth(mul_buffer_depth)
    ) output_buffer (
        .clk      (clk),
        .rst      (rst),
        .push     (mul_done),
        .push_data(mul_word),
        .push_tag (mul_tag),
        .pop      (drain),
        .valid    (valid),
        .data     (result),
        .data_tag (result_tag)
    );

endmodule

//--- source/result_fifo.sv
`timescale 1ns/1ps

module result_fifo #(
    parameter int depth = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic [mdu_pkg::xlen-1:0] push_data,
    input  mdu_pkg::tag_t            push_tag,
    input  logic                     pop,
    output logic                     valid,
    output logic [mdu_pkg::xlen-1:0] data,
    output mdu_pkg::tag_t            data_tag
);
    import mdu_pkg::*;

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    logic [xlen-1:0]        data_mem [depth];  // result words.
    tag_t                   tag_mem  [depth];  // matching tags.
    logic [ptr_width-1:0]   rd_ptr;
    logic [ptr_width-1:0]   wr_ptr;
    logic [count_width-1:0] count;             // entries held.
    logic                   pop_en;

    // pointers wrap at depth, which need not be a power of two.
    function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_en = pop & valid;  // ignore a pop on an empty buffer.

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop_en) rd_ptr <= ptr_inc(rd_ptr);
            if (push && !pop_en) begin
                count <= count + 1'b1;
            end else if (!push && pop_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= push_data;
            tag_mem[wr_ptr] <= push_tag;
        end
    end

    assign valid = (count != '0);
    assign data = data_mem[rd_ptr];     // head of the buffer.
    assign data_tag = tag_mem[rd_ptr];

endmodule

//--- source/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mul_valid,
    input  logic [mdu_pkg::xlen-1:0] mul_result,
    input  mdu_pkg::tag_t            mul_tag,
    output logic                     mul_accepted,
    input  logic                     div_valid,
    input  logic [mdu_pkg::xlen-1:0] div_result,
    input  mdu_pkg::tag_t            div_tag,
    output logic                     div_accepted,
    output logic                     wb_valid,
    output logic [mdu_pkg::xlen-1:0] wb_result,
    output mdu_pkg::tag_t            wb_tag,
    input  logic                     wb_accepted
);
    import mdu_pkg::*;

    logic last_div;  // last taken entry came from the divider.
    logic hold;      // output was offered but not taken.
    logic held_div;  // grant to keep while holding.
    logic sel_div;

    always_comb begin
        if (hold) sel_div = held_div;                           // keep the offer stable.
        else if (mul_valid && div_valid) sel_div = !last_div;   // alternate on contention.
        else sel_div = div_valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_div <= 1'b0;
            hold <= 1'b0;
            held_div <= 1'b0;
        end else begin
            hold <= wb_valid & ~wb_accepted;
            held_div <= sel_div;
            if (wb_valid && wb_accepted) last_div <= sel_div;  // moves only on a transfer.
        end
    end

    assign wb_valid = mul_valid | div_valid;
    assign wb_result = sel_div ? div_result : mul_result;
    assign wb_tag = sel_div ? div_tag : mul_tag;
    assign mul_accepted = wb_accepted & mul_valid & ~sel_div;
    assign div_accepted = wb_accepted & div_valid & sel_div;

endmodule

//--- verification/mdu_assert.sv
`timescale 1ns/1ps

module mdu_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     mul_request,
    input logic                     mul_ready,
    input logic                     div_request,
    input logic                     div_ready,
    input logic                     wb_valid,
    input logic [mdu_pkg::xlen-1:0] wb_result,
    input mdu_pkg::tag_t            wb_tag,
    input logic                     wb_accepted
);

    // an offered result holds until writeback takes it.
    stall_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && !wb_accepted) |=> ($stable(wb_result) && $stable(wb_tag)))
        else $error("wb_result or wb_tag changed while waiting for wb_accepted");

    // state right after a reset edge.
    reset_state: assert property (@(posedge clk)
        rst |=> (mul_ready && div_ready && !wb_valid))
        else $error("ready or wb_valid wrong after reset");

    mul_issue: assert property (@(posedge clk) disable iff (rst) mul_request |-> mul_ready)
        else $error("mul_request raised while mul_ready low");

    div_issue: assert property (@(posedge clk) disable iff (rst) div_request |-> div_ready)
        else $error("div_request raised while div_ready low");

endmodule

bind mdu_top mdu_assert protocol_check (
    .clk(clk), .rst(rst),
    .mul_request(mul_request), .mul_ready(mul_ready),
    .div_request(div_request), .div_ready(div_ready),
    .wb_valid(wb_valid), .wb_result(wb_result), .wb_tag(wb_tag),
    .wb_accepted(wb_accepted)
);

//--- verification/mdu_clock.sv
`timescale 1ns/1ps

module mdu_clock #(
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    // reset held over the first rising edges, released on an edge.
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verification/mdu_input.txt
# columns: name, op code, rs1, rs2, expected result; all numbers in hex.
# op code is funct3: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 div, 5 divu, 6 rem, 7 remu.
mul_small 0 00000007 00000006 0000002a
div_pos 4 00000014 00000003 00000006
mul_neg 0 fffffffd 00000005 fffffff1
mulh_pos 1 00010000 00010000 00000001
div_neg 4 ffffffec 00000003 fffffffa
mulh_neg1_sq 1 ffffffff ffffffff 00000000
mulh_min_sq 1 80000000 80000000 40000000
mulh_min_neg1 1 80000000 ffffffff 00000000
rem_neg 6 ffffffec 00000003 fffffffe
mul_min_neg1 0 80000000 ffffffff 80000000
mul_min_sq 0 80000000 80000000 00000000
div_neg_neg 4 ffffffec fffffffd 00000006
mulhsu_neg 2 ffffffff ffffffff ffffffff
mulhsu_pos 2 00000002 80000000 00000001
mulhsu_min 2 80000000 ffffffff 80000000
rem_neg_div 6 00000014 fffffffd 00000002
mulhu_max 3 ffffffff ffffffff fffffffe
mulhu_min 3 80000000 80000000 40000000
divu_big 5 ffffffec 00000003 5555554e
remu_big 7 ffffffec 00000003 00000002
div_by_zero 4 00001234 00000000 ffffffff
mul_shift 0 12345678 00000010 23456780
divu_by_zero 5 ffffffec 00000000 ffffffff
rem_by_zero 6 ffffffec 00000000 ffffffec
remu_by_zero 7 00001234 00000000 00001234
div_overflow 4 80000000 ffffffff 80000000
rem_overflow 6 80000000 ffffffff 00000000
divu_min_neg1 5 80000000 ffffffff 00000000
mulhu_small 3 00000003 00000004 00000000

//--- verification/mdu_tb.sv
`timescale 1ns/1ps

module mdu_tb;
    import mdu_pkg::*;

    localparam int max_tests = 64;
    localparam int tag_count = 1 << tag_width;
    localparam int mul_depth = 4;  // multiply output buffer entries.

    logic            clk;
    logic            rst;
    logic            mul_request;
    mdu_op_t         mul_op;
    logic [xlen-1:0] mul_rs1;
    logic [xlen-1:0] mul_rs2;
    tag_t            mul_tag;
    logic            mul_ready;
    logic            div_request;
    mdu_op_t         div_op;
    logic [xlen-1:0] div_rs1;
    logic [xlen-1:0] div_rs2;
    tag_t            div_tag;
    logic            div_ready;
    logic            wb_valid;
    logic [xlen-1:0] wb_result;
    tag_t            wb_tag;
    logic            wb_accepted;

    string           test_name [max_tests];     // one entry per data line.
    logic [2:0]      test_op   [max_tests];
    logic [xlen-1:0] test_rs1  [max_tests];
    logic [xlen-1:0] test_rs2  [max_tests];
    logic [xlen-1:0] test_exp  [max_tests];
    string           name_by_tag [tag_count];  // owner of each tag in flight.
    logic [xlen-1:0] exp_by_tag  [tag_count];
    logic            div_by_tag  [tag_count];
    int              issued      [tag_count];
    int              returned    [tag_count];
    int              num_tests = 0;
    int              pass_count = 0;
    int              fail_count = 0;
    int              cycles = 0;
    int              limit = 200;
    int              issue_index = 0;
    int              mul_open = 0;              // multiplies issued and not yet written back.
    int              bp_bits;
    logic [15:0]     lfsr_state = 16'd4727;

    mdu_clock clock_gen (.clk(clk), .rst(rst));

    mdu_top #(
        .mul_buffer_depth(mul_depth)
    ) DUT (
        .clk(clk), .rst(rst),
        .mul_request(mul_request), .mul_op(mul_op), .mul_rs1(mul_rs1), .mul_rs2(mul_rs2),
        .mul_tag(mul_tag), .mul_ready(mul_ready),
        .div_request(div_request), .div_op(div_op), .div_rs1(div_rs1), .div_rs2(div_rs2),
        .div_tag(div_tag), .div_ready(div_ready),
        .wb_valid(wb_valid), .wb_result(wb_result), .wb_tag(wb_tag),
        .wb_accepted(wb_accepted)
    );

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            value = (value << 1) | int'(lfsr_state[0]);  // one step per bit.
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            fail_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end else begin
            pass_count++;
            $display("   ok    %s: %h", name, actual);
        end
    endtask

    function automatic int pending_count();
        int total = 0;
        for (int t = 0; t < tag_count; t++) total += issued[t] - returned[t];
        return total;
    endfunction

    task automatic load_tests();
        int              fd;
        int              got;
        int              fields;
        string           line;
        string           name;
        logic [2:0]      op;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] expected;
        fd = $fopen("verification/mdu_input.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("cannot open verification/mdu_input.txt");
        end else begin
            while (!$feof(fd) && num_tests < max_tests) begin
                line = "";
                got = $fgets(line, fd);
                if (got > 1 && line.substr(0, 0) != "#") begin  // skip blanks and comments.
                    fields = $sscanf(line, "%s %h %h %h %h", name, op, rs1, rs2, expected);
                    if (fields == 5) begin
                        test_name[num_tests] = name;
                        test_op[num_tests] = op;
                        test_rs1[num_tests] = rs1;
                        test_rs2[num_tests] = rs2;
                        test_exp[num_tests] = expected;
                        num_tests++;
                    end else begin
                        fail_count++;
                        $display("data line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one request on the port the op code belongs to.
    // a multiply with no gap follows the previous request with no idle cycle.
    task automatic issue_test(input int i);
        tag_t    tag;
        mdu_op_t op;
        logic    use_div;
        logic    back_to_back;
        int      gap;
        tag = tag_t'(i % tag_count);
        op = mdu_op_t'(test_op[i]);
        use_div = is_div_op(op);
        draw_bits(2, gap);
        // mul_ready stays high past this edge while the open multiplies fit the buffer.
        back_to_back = !use_div && (gap == 0) && (issued[tag] == returned[tag])
                       && (mul_open < mul_depth);
        mul_request <= 1'b0;  // any earlier request is taken on this edge.
        div_request <= 1'b0;
        if (!back_to_back) begin
            while (issued[tag] != returned[tag]) @(posedge clk);  // tag still in flight.
            @(negedge clk);
            repeat (gap) @(negedge clk);                          // random idle cycles.
            while (!(use_div ? div_ready : mul_ready)) @(negedge clk);
            @(posedge clk);
        end
        name_by_tag[tag] = test_name[i];
        exp_by_tag[tag] = test_exp[i];
        div_by_tag[tag] = use_div;
        issued[tag]++;
        if (use_div) begin
            div_request <= 1'b1;
            div_op <= op;
            div_rs1 <= test_rs1[i];
            div_rs2 <= test_rs2[i];
            div_tag <= tag;
        end else begin
            mul_open++;
            mul_request <= 1'b1;
            mul_op <= op;
            mul_rs1 <= test_rs1[i];
            mul_rs2 <= test_rs2[i];
            mul_tag <= tag;
        end
        @(posedge clk);  // taken on this edge.
    endtask

    task automatic record_writeback();
        if (issued[wb_tag] == returned[wb_tag]) begin
            fail_count++;
            $display("writeback on tag %0d while no request with that tag is open", wb_tag);
        end else begin
            check_value(name_by_tag[wb_tag], exp_by_tag[wb_tag], wb_result);
            returned[wb_tag]++;
            if (!div_by_tag[wb_tag]) mul_open--;
        end
    endtask

    initial begin
        mul_request <= 1'b0;
        mul_op <= op_mul;
        mul_rs1 <= '0;
        mul_rs2 <= '0;
        mul_tag <= '0;
        div_request <= 1'b0;
        div_op <= op_div;
        div_rs1 <= '0;
        div_rs2 <= '0;
        div_tag <= '0;
        wb_accepted <= 1'b0;
        for (int t = 0; t < tag_count; t++) begin
            issued[t] = 0;
            returned[t] = 0;
        end
        load_tests();
        limit = num_tests * 40 + 200;  // worst case is a divide per test plus stalls.
        fork
            forever begin
                @(negedge clk);
                draw_bits(2, bp_bits);
                @(posedge clk);
                wb_accepted <= (bp_bits != 0);  // low one cycle in four.
            end
            forever begin
                @(negedge clk);                 // arbiter output settled here.
                if (!rst && wb_valid && wb_accepted) record_writeback();
            end
            forever begin
                @(posedge clk);
                cycles++;
                if (cycles >= limit) begin
                    $display("run stopped after %0d cycles without finishing", cycles);
                    for (int t = 0; t < tag_count; t++) begin
                        if (issued[t] != returned[t]) begin
                            $display("tag %0d (%s) never returned", t, name_by_tag[t]);
                        end
                    end
                    if (issue_index < num_tests) begin
                        $display("only %0d of %0d tests were issued", issue_index, num_tests);
                    end
                    $display("TEST FAILED");
                    $finish;
                end
            end
        join_none
        while (rst !== 1'b0) @(posedge clk);
        @(negedge clk);
        check_value("reset_state", 32'b110, {29'b0, mul_ready, div_ready, wb_valid});
        @(posedge clk);
        for (issue_index = 0; issue_index < num_tests; issue_index++) issue_test(issue_index);
        mul_request <= 1'b0;
        div_request <= 1'b0;
        while (pending_count() != 0) @(posedge clk);
        repeat (8) @(posedge clk);  // room for a duplicate writeback to show.
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
